//--- logic/ip_stack_pkg.sv
//********************************************************************
// IP offload shared definitions
// Field widths, register map, reset defaults, MAC command words and
// the state encodings of the bring-up sequencer and transmit arbiter
//********************************************************************

package ip_stack_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [15:0] ip_len_t;
    typedef logic [7:0]  byte_t;
    typedef logic [5:0]  dscp_t;
    typedef logic [1:0]  ecn_t;
    typedef logic [31:0] count_t;

    // Register map
    localparam reg_addr_t ADDR_MAC_CMD   = 8'h02;
    localparam reg_addr_t ADDR_MAC_LO    = 8'h03;
    localparam reg_addr_t ADDR_MAC_HI    = 8'h04;
    localparam reg_addr_t ADDR_LOCAL_IP  = 8'hf0;
    localparam reg_addr_t ADDR_SUBNET    = 8'hf1;
    localparam reg_addr_t ADDR_GATEWAY   = 8'hf2;
    localparam reg_addr_t ADDR_REPLY_CNT = 8'hf4;
    localparam reg_addr_t ADDR_HOST_CNT  = 8'hf5;

    // 192.168.1.1, 255.255.255.0, 192.168.1.253
    localparam ip_addr_t DEFAULT_LOCAL_IP = 32'hc0a8_0101;
    localparam ip_addr_t DEFAULT_SUBNET   = 32'hffff_ff00;
    localparam ip_addr_t DEFAULT_GATEWAY  = 32'hc0a8_01fd;

    // Bits 31 and 13 of the command word clear the statistics
    localparam reg_data_t CMD_CLEAR_BITS = 32'h8000_2000;
    localparam reg_data_t CMD_RESET      = 32'h0000_2000;
    // TX enable, RX enable, gigabit
    localparam reg_data_t CMD_ENABLE     = 32'h0000_000b;

    typedef enum logic [1:0] {
        WAIT,
        WRITE_RESET,
        WRITE_ENABLE,
        DONE
    } init_state_t;

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD
    } arb_state_t;

endpackage

//--- logic/mac_init_seq.sv
//********************************************************************
// MAC bring-up sequencer
// Owns the register bus after reset, writes the reset and enable
// commands, then hands the bus over to the host
//********************************************************************
`timescale 1ns/1ns

module mac_init_seq #(
    parameter int INIT_WAIT = 16
) (
    input  logic                    clk_2,
    input  logic                    rst,
    input  ip_stack_pkg::reg_addr_t reg_addr,
    input  logic                    reg_wr,
    input  ip_stack_pkg::reg_data_t reg_writedata,
    output ip_stack_pkg::reg_addr_t bus_addr,
    output logic                    bus_wr,
    output ip_stack_pkg::reg_data_t bus_writedata,
    output logic                    reg_busy
);

    localparam int CNT_W = $clog2(INIT_WAIT + 1);

    ip_stack_pkg::init_state_t state;
    logic [CNT_W-1:0]          wait_cnt;

    always_ff @(posedge clk_2) begin
        if (rst) begin
            state    <= ip_stack_pkg::WAIT;
            wait_cnt <= '0;
        end else begin
            case (state)
                ip_stack_pkg::WAIT: begin
                    if (wait_cnt == CNT_W'(INIT_WAIT - 1)) begin
                        state <= ip_stack_pkg::WRITE_RESET;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ip_stack_pkg::WRITE_RESET:  state <= ip_stack_pkg::WRITE_ENABLE;
                ip_stack_pkg::WRITE_ENABLE: state <= ip_stack_pkg::DONE;
                default:                    state <= state;
            endcase
        end
    end

    // Bus source select
    always_comb begin
        bus_addr      = ip_stack_pkg::ADDR_MAC_CMD;
        bus_wr        = 1'b0;
        bus_writedata = ip_stack_pkg::CMD_RESET;
        case (state)
            ip_stack_pkg::WRITE_RESET: begin
                bus_wr = 1'b1;
            end
            ip_stack_pkg::WRITE_ENABLE: begin
                bus_wr        = 1'b1;
                bus_writedata = ip_stack_pkg::CMD_ENABLE;
            end
            ip_stack_pkg::DONE: begin
                bus_addr      = reg_addr;
                bus_wr        = reg_wr;
                bus_writedata = reg_writedata;
            end
            default: ;
        endcase
    end

    // Host writes are dropped until this falls
    assign reg_busy = (state != ip_stack_pkg::DONE);

endmodule

//--- logic/cfg_regs.sv
//********************************************************************
// Configuration register bank
// Address, MAC and command registers with write decode, counter
// clear decode and combinational read-back
//********************************************************************
`timescale 1ns/1ns

module cfg_regs (
    input  logic                     clk_2,
    input  logic                     rst,
    input  ip_stack_pkg::reg_addr_t  bus_addr,
    input  logic                     bus_wr,
    input  ip_stack_pkg::reg_data_t  bus_writedata,
    input  ip_stack_pkg::reg_addr_t  reg_addr,
    output ip_stack_pkg::reg_data_t  reg_readdata,
    input  ip_stack_pkg::count_t     reply_count,
    input  ip_stack_pkg::count_t     host_count,
    output logic                     clear_counters,
    output ip_stack_pkg::ip_addr_t   local_ip,
    output ip_stack_pkg::ip_addr_t   subnet_mask,
    output ip_stack_pkg::ip_addr_t   gateway_ip,
    output ip_stack_pkg::mac_addr_t  local_mac,
    output ip_stack_pkg::reg_data_t  mac_cmd
);

    always_ff @(posedge clk_2) begin
        if (rst) begin
            mac_cmd     <= '0;
            local_mac   <= '0;
            local_ip    <= ip_stack_pkg::DEFAULT_LOCAL_IP;
            subnet_mask <= ip_stack_pkg::DEFAULT_SUBNET;
            gateway_ip  <= ip_stack_pkg::DEFAULT_GATEWAY;
        end else if (bus_wr) begin
            case (bus_addr)
                ip_stack_pkg::ADDR_MAC_CMD:  mac_cmd           <= bus_writedata;
                ip_stack_pkg::ADDR_MAC_LO:   local_mac[31:0]   <= bus_writedata;
                // Upper two MAC bytes only
                ip_stack_pkg::ADDR_MAC_HI:   local_mac[47:32]  <= bus_writedata[15:0];
                ip_stack_pkg::ADDR_LOCAL_IP: local_ip          <= bus_writedata;
                ip_stack_pkg::ADDR_SUBNET:   subnet_mask       <= bus_writedata;
                ip_stack_pkg::ADDR_GATEWAY:  gateway_ip        <= bus_writedata;
                default: ;
            endcase
        end
    end

    // Pulse on a command write carrying either clear bit
    assign clear_counters = bus_wr && (bus_addr == ip_stack_pkg::ADDR_MAC_CMD) &&
                            |(bus_writedata & ip_stack_pkg::CMD_CLEAR_BITS);

    always_comb begin
        case (reg_addr)
            ip_stack_pkg::ADDR_MAC_CMD:   reg_readdata = mac_cmd;
            ip_stack_pkg::ADDR_MAC_LO:    reg_readdata = local_mac[31:0];
            ip_stack_pkg::ADDR_MAC_HI:    reg_readdata = {16'h0000, local_mac[47:32]};
            ip_stack_pkg::ADDR_LOCAL_IP:  reg_readdata = local_ip;
            ip_stack_pkg::ADDR_SUBNET:    reg_readdata = subnet_mask;
            ip_stack_pkg::ADDR_GATEWAY:   reg_readdata = gateway_ip;
            ip_stack_pkg::ADDR_REPLY_CNT: reg_readdata = reply_count;
            ip_stack_pkg::ADDR_HOST_CNT:  reg_readdata = host_count;
            default:                      reg_readdata = '0;
        endcase
    end

endmodule

//--- logic/tx_frame_stats.sv
//********************************************************************
// Transmit frame statistics
// Completed-frame counters for the host and reply sources
//********************************************************************
`timescale 1ns/1ns

module tx_frame_stats (
    input  logic                 clk_2,
    input  logic                 rst,
    input  logic                 clear_counters,
    input  logic                 host_frame_done,
    input  logic                 reply_frame_done,
    output ip_stack_pkg::count_t host_count,
    output ip_stack_pkg::count_t reply_count
);

    // Clear has priority over a done pulse in the same cycle
    always_ff @(posedge clk_2) begin
        if (rst || clear_counters) begin
            host_count  <= '0;
            reply_count <= '0;
        end else begin
            if (host_frame_done) begin
                host_count <= host_count + 1'b1;
            end
            if (reply_frame_done) begin
                reply_count <= reply_count + 1'b1;
            end
        end
    end

endmodule

//--- logic/ip_tx_arbiter.sv
//********************************************************************
// IP transmit arbiter
// Merges host and reply frames onto one output, frame by frame,
// with the host port taking priority
//********************************************************************
`timescale 1ns/1ns

module ip_tx_arbiter (
    input  logic                   clk_2,
    input  logic                   rst,

    input  logic                   host_hdr_valid,
    output logic                   host_hdr_ready,
    input  ip_stack_pkg::dscp_t    host_dscp,
    input  ip_stack_pkg::ecn_t     host_ecn,
    input  ip_stack_pkg::ip_len_t  host_length,
    input  logic [7:0]             host_ttl,
    input  logic [7:0]             host_protocol,
    input  ip_stack_pkg::ip_addr_t host_source_ip,
    input  ip_stack_pkg::ip_addr_t host_dest_ip,
    input  ip_stack_pkg::byte_t    host_tdata,
    input  logic                   host_tvalid,
    output logic                   host_tready,
    input  logic                   host_tlast,
    input  logic                   host_tuser,

    input  logic                   reply_hdr_valid,
    output logic                   reply_hdr_ready,
    input  ip_stack_pkg::dscp_t    reply_dscp,
    input  ip_stack_pkg::ecn_t     reply_ecn,
    input  ip_stack_pkg::ip_len_t  reply_length,
    input  logic [7:0]             reply_ttl,
    input  logic [7:0]             reply_protocol,
    input  ip_stack_pkg::ip_addr_t reply_source_ip,
    input  ip_stack_pkg::ip_addr_t reply_dest_ip,
    input  ip_stack_pkg::byte_t    reply_tdata,
    input  logic                   reply_tvalid,
    output logic                   reply_tready,
    input  logic                   reply_tlast,
    input  logic                   reply_tuser,

    output logic                   out_hdr_valid,
    input  logic                   out_hdr_ready,
    output ip_stack_pkg::dscp_t    out_dscp,
    output ip_stack_pkg::ecn_t     out_ecn,
    output ip_stack_pkg::ip_len_t  out_length,
    output logic [7:0]             out_ttl,
    output logic [7:0]             out_protocol,
    output ip_stack_pkg::ip_addr_t out_source_ip,
    output ip_stack_pkg::ip_addr_t out_dest_ip,
    output ip_stack_pkg::byte_t    out_tdata,
    output logic                   out_tvalid,
    input  logic                   out_tready,
    output logic                   out_tlast,
    output logic                   out_tuser,

    output logic                   host_frame_done,
    output logic                   reply_frame_done
);

    ip_stack_pkg::arb_state_t state;
    logic grant_reply;
    logic payload_done;
    logic hdr_accept;
    logic payload_active;
    logic last_hs;

    // Host wins a tie in IDLE
    assign host_hdr_ready  = (state == ip_stack_pkg::IDLE);
    assign reply_hdr_ready = (state == ip_stack_pkg::IDLE) && !host_hdr_valid;
    assign hdr_accept      = (state == ip_stack_pkg::IDLE) && (host_hdr_valid || reply_hdr_valid);
    assign out_hdr_valid   = (state == ip_stack_pkg::HEADER);

    // Payload runs alongside a pending header
    assign payload_active = (state != ip_stack_pkg::IDLE) && !payload_done;
    assign out_tvalid     = payload_active && (grant_reply ? reply_tvalid : host_tvalid);
    assign out_tdata      = grant_reply ? reply_tdata : host_tdata;
    assign out_tlast      = grant_reply ? reply_tlast : host_tlast;
    assign out_tuser      = grant_reply ? reply_tuser : host_tuser;
    assign host_tready    = payload_active && !grant_reply && out_tready;
    assign reply_tready   = payload_active && grant_reply && out_tready;

    assign last_hs          = out_tvalid && out_tready && out_tlast;
    assign host_frame_done  = last_hs && !grant_reply;
    assign reply_frame_done = last_hs && grant_reply;

    always_ff @(posedge clk_2) begin
        if (rst) begin
            state        <= ip_stack_pkg::IDLE;
            grant_reply  <= 1'b0;
            payload_done <= 1'b0;
        end else begin
            case (state)
                ip_stack_pkg::IDLE: begin
                    if (hdr_accept) begin
                        grant_reply  <= !host_hdr_valid;
                        payload_done <= 1'b0;
                        state        <= ip_stack_pkg::HEADER;
                    end
                end
                ip_stack_pkg::HEADER: begin
                    if (out_hdr_ready) begin
                        if (payload_done || last_hs) begin
                            state <= ip_stack_pkg::IDLE;
                        end else begin
                            state <= ip_stack_pkg::PAYLOAD;
                        end
                    end else if (last_hs) begin
                        payload_done <= 1'b1;
                    end
                end
                ip_stack_pkg::PAYLOAD: begin
                    if (last_hs) begin
                        state <= ip_stack_pkg::IDLE;
                    end
                end
                default: state <= ip_stack_pkg::IDLE;
            endcase
        end
    end

    // Header capture
    always_ff @(posedge clk_2) begin
        if (hdr_accept) begin
            out_dscp      <= host_hdr_valid ? host_dscp      : reply_dscp;
            out_ecn       <= host_hdr_valid ? host_ecn       : reply_ecn;
            out_length    <= host_hdr_valid ? host_length    : reply_length;
            out_ttl       <= host_hdr_valid ? host_ttl       : reply_ttl;
            out_protocol  <= host_hdr_valid ? host_protocol  : reply_protocol;
            out_source_ip <= host_hdr_valid ? host_source_ip : reply_source_ip;
            out_dest_ip   <= host_hdr_valid ? host_dest_ip   : reply_dest_ip;
        end
    end

endmodule

//--- logic/ip_stack_top.sv
//********************************************************************
// UDP/IP offload control plane and transmit path
// Bring-up sequencer, register bank, frame statistics and the
// two-port transmit arbiter
//********************************************************************
`timescale 1ns/1ns

module ip_stack_top #(
    parameter int INIT_WAIT = 16
) (
    input  logic                    clk_2,
    input  logic                    rst,

    input  ip_stack_pkg::reg_addr_t reg_addr,
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  ip_stack_pkg::reg_data_t reg_writedata,
    output ip_stack_pkg::reg_data_t reg_readdata,
    output logic                    reg_busy,

    input  logic                    host_hdr_valid,
    output logic                    host_hdr_ready,
    input  ip_stack_pkg::dscp_t     host_dscp,
    input  ip_stack_pkg::ecn_t      host_ecn,
    input  ip_stack_pkg::ip_len_t   host_length,
    input  logic [7:0]              host_ttl,
    input  logic [7:0]              host_protocol,
    input  ip_stack_pkg::ip_addr_t  host_source_ip,
    input  ip_stack_pkg::ip_addr_t  host_dest_ip,
    input  ip_stack_pkg::byte_t     host_tdata,
    input  logic                    host_tvalid,
    output logic                    host_tready,
    input  logic                    host_tlast,
    input  logic                    host_tuser,

    input  logic                    reply_hdr_valid,
    output logic                    reply_hdr_ready,
    input  ip_stack_pkg::dscp_t     reply_dscp,
    input  ip_stack_pkg::ecn_t      reply_ecn,
    input  ip_stack_pkg::ip_len_t   reply_length,
    input  logic [7:0]              reply_ttl,
    input  logic [7:0]              reply_protocol,
    input  ip_stack_pkg::ip_addr_t  reply_source_ip,
    input  ip_stack_pkg::ip_addr_t  reply_dest_ip,
    input  ip_stack_pkg::byte_t     reply_tdata,
    input  logic                    reply_tvalid,
    output logic                    reply_tready,
    input  logic                    reply_tlast,
    input  logic                    reply_tuser,

    output logic                    out_hdr_valid,
    input  logic                    out_hdr_ready,
    output ip_stack_pkg::dscp_t     out_dscp,
    output ip_stack_pkg::ecn_t      out_ecn,
    output ip_stack_pkg::ip_len_t   out_length,
    output logic [7:0]              out_ttl,
    output logic [7:0]              out_protocol,
    output ip_stack_pkg::ip_addr_t  out_source_ip,
    output ip_stack_pkg::ip_addr_t  out_dest_ip,
    output ip_stack_pkg::byte_t     out_tdata,
    output logic                    out_tvalid,
    input  logic                    out_tready,
    output logic                    out_tlast,
    output logic                    out_tuser,

    output ip_stack_pkg::ip_addr_t  local_ip,
    output ip_stack_pkg::ip_addr_t  subnet_mask,
    output ip_stack_pkg::ip_addr_t  gateway_ip,
    output ip_stack_pkg::mac_addr_t local_mac,
    // Command word for a MAC attached later
    output ip_stack_pkg::reg_data_t mac_cmd
);

    // Sequencer to register bank
    ip_stack_pkg::reg_addr_t bus_addr;
    logic                    bus_wr;
    ip_stack_pkg::reg_data_t bus_writedata;

    logic                    clear_counters;
    logic                    host_frame_done;
    logic                    reply_frame_done;
    ip_stack_pkg::count_t    host_count;
    ip_stack_pkg::count_t    reply_count;

    mac_init_seq #(
        .INIT_WAIT(INIT_WAIT)
    ) u_mac_init_seq (
        .*
    );

    cfg_regs u_cfg_regs (
        .*
    );

    tx_frame_stats u_tx_frame_stats (
        .*
    );

    ip_tx_arbiter u_ip_tx_arbiter (
        .*
    );

endmodule

//--- tb/tb_ip_stack.sv
//********************************************************************
// Testbench for the UDP/IP offload control plane and transmit path
// Checks bring-up, register access, arbitration and frame counters
//********************************************************************
`timescale 1ns/1ns

module tb_ip_stack;

    localparam int TIMEOUT_CYCLES = 500;

    logic                    clk_2;
    logic                    rst;
    ip_stack_pkg::reg_addr_t reg_addr;
    logic                    reg_wr;
    logic                    reg_rd;
    ip_stack_pkg::reg_data_t reg_writedata;
    ip_stack_pkg::reg_data_t reg_readdata;
    logic                    reg_busy;

    logic                    host_hdr_valid, host_hdr_ready;
    ip_stack_pkg::dscp_t     host_dscp;
    ip_stack_pkg::ecn_t      host_ecn;
    ip_stack_pkg::ip_len_t   host_length;
    logic [7:0]              host_ttl, host_protocol;
    ip_stack_pkg::ip_addr_t  host_source_ip, host_dest_ip;
    ip_stack_pkg::byte_t     host_tdata;
    logic                    host_tvalid, host_tready, host_tlast, host_tuser;

    logic                    reply_hdr_valid, reply_hdr_ready;
    ip_stack_pkg::dscp_t     reply_dscp;
    ip_stack_pkg::ecn_t      reply_ecn;
    ip_stack_pkg::ip_len_t   reply_length;
    logic [7:0]              reply_ttl, reply_protocol;
    ip_stack_pkg::ip_addr_t  reply_source_ip, reply_dest_ip;
    ip_stack_pkg::byte_t     reply_tdata;
    logic                    reply_tvalid, reply_tready, reply_tlast, reply_tuser;

    logic                    out_hdr_valid, out_hdr_ready;
    ip_stack_pkg::dscp_t     out_dscp;
    ip_stack_pkg::ecn_t      out_ecn;
    ip_stack_pkg::ip_len_t   out_length;
    logic [7:0]              out_ttl, out_protocol;
    ip_stack_pkg::ip_addr_t  out_source_ip, out_dest_ip;
    ip_stack_pkg::byte_t     out_tdata;
    logic                    out_tvalid, out_tready, out_tlast, out_tuser;

    ip_stack_pkg::ip_addr_t  local_ip, subnet_mask, gateway_ip;
    ip_stack_pkg::mac_addr_t local_mac;
    ip_stack_pkg::reg_data_t mac_cmd;

    // Header word is {dscp, ecn, length, ttl, protocol, source, dest}
    logic [103:0] exp_hdrs[$];
    logic [103:0] out_hdrs[$];
    // Byte entry is {tuser, tlast, tdata}
    logic [9:0]   exp_bytes[$];
    logic [9:0]   out_bytes[$];

    logic [103:0] host_frame_hdr, reply_frame_hdr;
    logic [9:0]   host_payload[0:63];
    logic [9:0]   reply_payload[0:63];
    int           host_len, reply_len;
    int           host_sent, reply_sent;
    logic         bp_on;

    ip_stack_top UUT (.*);

    always #50 clk_2 = ~clk_2;

    // Sink back-pressure
    always @(posedge clk_2) begin
        #1;
        if (bp_on) begin
            out_hdr_ready = $urandom_range(0, 1);
            out_tready    = $urandom_range(0, 1);
        end else begin
            out_hdr_ready = 1'b1;
            out_tready    = 1'b1;
        end
    end

    // Output handshakes sampled ahead of the completing rising edge
    always @(negedge clk_2) begin
        if (!rst) begin
            if (out_hdr_valid && out_hdr_ready) begin
                out_hdrs.push_back({out_dscp, out_ecn, out_length, out_ttl, out_protocol,
                                    out_source_ip, out_dest_ip});
            end
            if (out_tvalid && out_tready) begin
                out_bytes.push_back({out_tuser, out_tlast, out_tdata});
            end
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else begin
            report_failure($sformatf("error: time %0t %s expected %0h actual %0h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic bus_write(input ip_stack_pkg::reg_addr_t addr,
                             input ip_stack_pkg::reg_data_t data);
        reg_addr      = addr;
        reg_writedata = data;
        reg_wr        = 1'b1;
        @(posedge clk_2);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic bus_read(input ip_stack_pkg::reg_addr_t addr,
                            output ip_stack_pkg::reg_data_t data);
        reg_addr = addr;
        reg_rd   = 1'b1;
        @(negedge clk_2);
        data = reg_readdata;
        @(posedge clk_2);
        #1;
        reg_rd = 1'b0;
    endtask

    task automatic read_check(input ip_stack_pkg::reg_addr_t addr,
                              input ip_stack_pkg::reg_data_t expected);
        ip_stack_pkg::reg_data_t data;
        bus_read(addr, data);
        check_value($sformatf("reg_readdata[%0h]", addr), expected, data);
    endtask

    task automatic wait_busy_low();
        int guard;
        guard = 0;
        @(negedge clk_2);
        while (reg_busy) begin
            guard++;
            if (guard > 100) begin
                report_failure($sformatf("timeout at %0t: reg_busy never fell", $time));
            end
            @(negedge clk_2);
        end
        @(posedge clk_2);
        #1;
    endtask

    function automatic logic [103:0] random_header();
        logic [127:0] r;
        r = {$urandom(), $urandom(), $urandom(), $urandom()};
        return r[103:0];
    endfunction

    function automatic logic ready_of(input bit to_reply, input bit is_hdr);
        if (is_hdr) begin
            return to_reply ? reply_hdr_ready : host_hdr_ready;
        end
        return to_reply ? reply_tready : host_tready;
    endfunction

    // Random header and payload for one port, queued as expected output
    task automatic build_frame(input bit to_reply, input int nbytes);
        logic [103:0] h;
        logic [9:0]   b;
        int           i;
        h = random_header();
        exp_hdrs.push_back(h);
        if (to_reply) begin
            reply_frame_hdr = h;
            reply_len       = nbytes;
        end else begin
            host_frame_hdr = h;
            host_len       = nbytes;
        end
        for (i = 0; i < nbytes; i++) begin
            b = {1'($urandom_range(0, 1)), (i == nbytes - 1), 8'($urandom())};
            exp_bytes.push_back(b);
            if (to_reply) reply_payload[i] = b;
            else host_payload[i] = b;
        end
    endtask

    task automatic drive_header(input bit to_reply, input logic valid, input logic [103:0] h);
        if (to_reply) begin
            reply_hdr_valid = valid;
            {reply_dscp, reply_ecn, reply_length, reply_ttl, reply_protocol,
             reply_source_ip, reply_dest_ip} = h;
        end else begin
            host_hdr_valid = valid;
            {host_dscp, host_ecn, host_length, host_ttl, host_protocol,
             host_source_ip, host_dest_ip} = h;
        end
    endtask

    task automatic drive_byte(input bit to_reply, input logic valid, input logic [9:0] b);
        if (to_reply) begin
            reply_tvalid = valid;
            {reply_tuser, reply_tlast, reply_tdata} = b;
        end else begin
            host_tvalid = valid;
            {host_tuser, host_tlast, host_tdata} = b;
        end
    endtask

    task automatic wait_handshake(input bit to_reply, input bit is_hdr);
        int guard;
        guard = 0;
        @(negedge clk_2);
        while (!ready_of(to_reply, is_hdr)) begin
            guard++;
            if (guard > TIMEOUT_CYCLES) begin
                report_failure($sformatf("timeout at %0t: %s port never accepted a %s",
                               $time, to_reply ? "reply" : "host",
                               is_hdr ? "header" : "payload byte"));
            end
            @(negedge clk_2);
        end
        @(posedge clk_2);
        #1;
    endtask

    task automatic send_frame(input bit to_reply);
        logic [9:0] b;
        int         n;
        int         i;
        n = to_reply ? reply_len : host_len;
        drive_header(to_reply, 1'b1, to_reply ? reply_frame_hdr : host_frame_hdr);
        wait_handshake(to_reply, 1'b1);
        drive_header(to_reply, 1'b0, 104'h0);
        for (i = 0; i < n; i++) begin
            b = to_reply ? reply_payload[i] : host_payload[i];
            // Occasional source gap
            if ($urandom_range(0, 3) == 0) begin
                drive_byte(to_reply, 1'b0, b);
                @(posedge clk_2);
                #1;
            end
            drive_byte(to_reply, 1'b1, b);
            wait_handshake(to_reply, 1'b0);
        end
        drive_byte(to_reply, 1'b0, 10'h0);
        if (to_reply) reply_sent++;
        else host_sent++;
    endtask

    task automatic check_frames();
        int guard;
        int i;
        guard = 0;
        while (out_hdrs.size() < exp_hdrs.size() || out_bytes.size() < exp_bytes.size()) begin
            guard++;
            if (guard > TIMEOUT_CYCLES) begin
                report_failure($sformatf("timeout at %0t: output frames incomplete", $time));
            end
            @(posedge clk_2);
        end
        repeat (2) @(posedge clk_2);
        #1;
        check_value("out header count", exp_hdrs.size(), out_hdrs.size());
        check_value("out byte count", exp_bytes.size(), out_bytes.size());
        for (i = 0; i < exp_hdrs.size(); i++) begin
            check_value($sformatf("out header fields %0d", i), exp_hdrs[i], out_hdrs[i]);
        end
        for (i = 0; i < exp_bytes.size(); i++) begin
            check_value($sformatf("{out_tuser,out_tlast,out_tdata} %0d", i),
                        exp_bytes[i], out_bytes[i]);
        end
        exp_hdrs.delete();
        out_hdrs.delete();
        exp_bytes.delete();
        out_bytes.delete();
    endtask

    initial begin
        void'($urandom(32'h70f2_2679));
        clk_2 = 1'b0;
        rst = 1'b1;
        {reg_addr, reg_wr, reg_rd, reg_writedata} = '0;
        drive_header(1'b0, 1'b0, 104'h0);
        drive_header(1'b1, 1'b0, 104'h0);
        drive_byte(1'b0, 1'b0, 10'h0);
        drive_byte(1'b1, 1'b0, 10'h0);
        out_hdr_ready = 1'b1;
        out_tready = 1'b1;
        bp_on = 1'b0;
        host_sent = 0;
        reply_sent = 0;
        repeat (10) @(posedge clk_2);
        #1;
        rst = 1'b0;

        // Bring-up state and a write that must be dropped while busy
        check_value("reg_busy", 1, reg_busy);
        check_value("out_hdr_valid", 0, out_hdr_valid);
        check_value("out_tvalid", 0, out_tvalid);
        bus_write(ip_stack_pkg::ADDR_LOCAL_IP, 32'h0a00_0001);
        wait_busy_low();
        read_check(ip_stack_pkg::ADDR_MAC_CMD, 32'h0000_000b);
        read_check(ip_stack_pkg::ADDR_LOCAL_IP, 32'hc0a8_0101);
        read_check(ip_stack_pkg::ADDR_SUBNET, 32'hffff_ff00);
        read_check(ip_stack_pkg::ADDR_GATEWAY, 32'hc0a8_01fd);
        read_check(ip_stack_pkg::ADDR_HOST_CNT, 0);
        read_check(ip_stack_pkg::ADDR_REPLY_CNT, 0);
        check_value("mac_cmd", 32'h0000_000b, mac_cmd);
        check_value("local_ip", 32'hc0a8_0101, local_ip);
        check_value("subnet_mask", 32'hffff_ff00, subnet_mask);
        check_value("gateway_ip", 32'hc0a8_01fd, gateway_ip);

        // Host register access
        bus_write(ip_stack_pkg::ADDR_LOCAL_IP, 32'h0a00_0002);
        bus_write(ip_stack_pkg::ADDR_SUBNET, 32'hffff_0000);
        bus_write(ip_stack_pkg::ADDR_GATEWAY, 32'h0a00_00fe);
        bus_write(ip_stack_pkg::ADDR_MAC_LO, 32'h3344_5566);
        bus_write(ip_stack_pkg::ADDR_MAC_HI, 32'habcd_0011);
        read_check(ip_stack_pkg::ADDR_LOCAL_IP, 32'h0a00_0002);
        read_check(ip_stack_pkg::ADDR_SUBNET, 32'hffff_0000);
        read_check(ip_stack_pkg::ADDR_GATEWAY, 32'h0a00_00fe);
        read_check(ip_stack_pkg::ADDR_MAC_LO, 32'h3344_5566);
        read_check(ip_stack_pkg::ADDR_MAC_HI, 32'h0000_0011);
        read_check(8'h55, 0);
        check_value("local_ip", 32'h0a00_0002, local_ip);
        check_value("local_mac", 48'h0011_3344_5566, local_mac);

        // Single reply frame without back-pressure
        build_frame(1'b1, 8);
        send_frame(1'b1);
        check_frames();

        // Same-cycle headers with host priority
        bp_on = 1'b1;
        build_frame(1'b0, 12);
        build_frame(1'b1, 9);
        fork
            send_frame(1'b0);
            send_frame(1'b1);
        join
        check_frames();

        // More host frames for the counters
        for (int k = 0; k < 3; k++) begin
            build_frame(1'b0, 3 + k * 4);
            send_frame(1'b0);
            check_frames();
        end
        read_check(ip_stack_pkg::ADDR_HOST_CNT, host_sent);
        read_check(ip_stack_pkg::ADDR_REPLY_CNT, reply_sent);
        bus_write(ip_stack_pkg::ADDR_MAC_CMD, 32'h8000_000b);
        read_check(ip_stack_pkg::ADDR_HOST_CNT, 0);
        read_check(ip_stack_pkg::ADDR_REPLY_CNT, 0);
        check_value("mac_cmd", 32'h8000_000b, mac_cmd);

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- vlog.f
logic/ip_stack_pkg.sv
logic/mac_init_seq.sv
logic/cfg_regs.sv
logic/tx_frame_stats.sv
logic/ip_tx_arbiter.sv
logic/ip_stack_top.sv
tb/tb_ip_stack.sv

//--- Bender.yml
package:
  name: ip_stack

sources:
  - logic/ip_stack_pkg.sv
  - logic/mac_init_seq.sv
  - logic/cfg_regs.sv
  - logic/tx_frame_stats.sv
  - logic/ip_tx_arbiter.sv
  - logic/ip_stack_top.sv
  - target: test
    files:
      - tb/tb_ip_stack.sv
